//--- logic/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire [rv_backend_pkg::XLEN-1:0]         i_pc,
    input  wire [31:0]                             i_inst,
    input  wire [rv_backend_pkg::XLEN-1:0]         i_rs1_data,
    input  wire [rv_backend_pkg::XLEN-1:0]         i_rs2_data,
    input  wire [rv_backend_pkg::DBG_TAG_BITS-1:0] i_dbg_tag,
    stage_if.producer                              o_ex
);

    rv_backend_pkg::inst_u           inst;
    logic [6:0]                      opcode;
    logic [2:0]                      funct3;
    logic [rv_backend_pkg::XLEN-1:0] imm_i;
    logic [rv_backend_pkg::XLEN-1:0] imm_s;
    logic [rv_backend_pkg::XLEN-1:0] op_b;
    logic [rv_backend_pkg::XLEN-1:0] alu_out;
    logic                            is_alu;
    logic                            is_sub;
    logic                            rd_nonzero;

    assign inst   = i_inst;
    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.i_fmt.funct3;

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};

    assign is_alu     = (opcode == rv_backend_pkg::OPC_OP) || (opcode == rv_backend_pkg::OPC_OP_IMM);
    assign is_sub     = (opcode == rv_backend_pkg::OPC_OP)
                     && (inst.r_fmt.funct7 == rv_backend_pkg::FUNCT7_ALT);
    assign rd_nonzero = (inst.r_fmt.rd != '0);

    always_comb begin
        if (opcode == rv_backend_pkg::OPC_OP)
            op_b = i_rs2_data;
        else if (opcode == rv_backend_pkg::OPC_STORE)
            op_b = imm_s;
        else
            op_b = imm_i;  // OP_IMM, LOAD and JALR
    end

    always_comb begin
        if (!is_alu) begin
            alu_out = i_rs1_data + op_b;  // Address or jump target
        end else begin
            case (funct3)
                rv_backend_pkg::F3_ADD_SUB: alu_out = is_sub ? i_rs1_data - op_b : i_rs1_data + op_b;
                rv_backend_pkg::F3_SLL:     alu_out = i_rs1_data << op_b[4:0];
                rv_backend_pkg::F3_SLT:     alu_out = {{(rv_backend_pkg::XLEN-1){1'b0}},
                                                       $signed(i_rs1_data) < $signed(op_b)};
                rv_backend_pkg::F3_XOR:     alu_out = i_rs1_data ^ op_b;
                rv_backend_pkg::F3_SRL:     alu_out = i_rs1_data >> op_b[4:0];  // Logical only
                rv_backend_pkg::F3_OR:      alu_out = i_rs1_data | op_b;
                rv_backend_pkg::F3_AND:     alu_out = i_rs1_data & op_b;
                default:                    alu_out = '0;  // SLTU not supported
            endcase
        end
    end

    always_comb begin
        o_ex.reg_wr_enable   = 1'b0;
        o_ex.mem_wr_enable   = 1'b0;
        o_ex.is_load         = 1'b0;
        o_ex.reg_wr_data_sel = rv_backend_pkg::WB_SEL_ALU;
        case (opcode)
            rv_backend_pkg::OPC_OP,
            rv_backend_pkg::OPC_OP_IMM: o_ex.reg_wr_enable = rd_nonzero;
            rv_backend_pkg::OPC_LOAD: begin
                if (funct3 == rv_backend_pkg::F3_WORD) begin  // Word loads only
                    o_ex.reg_wr_enable   = rd_nonzero;
                    o_ex.is_load         = 1'b1;
                    o_ex.reg_wr_data_sel = rv_backend_pkg::WB_SEL_MEM;
                end
            end
            rv_backend_pkg::OPC_STORE: o_ex.mem_wr_enable = (funct3 == rv_backend_pkg::F3_WORD);
            rv_backend_pkg::OPC_JALR: begin
                o_ex.reg_wr_enable   = rd_nonzero;
                o_ex.reg_wr_data_sel = rv_backend_pkg::WB_SEL_LINK;
            end
            default: ;  // Bubble
        endcase
    end

    assign o_ex.pc          = i_pc;
    assign o_ex.inst_op     = opcode;
    assign o_ex.result      = alu_out;
    assign o_ex.data_b      = i_rs2_data;  // Store data
    assign o_ex.reg_wr_addr = inst.r_fmt.rd;
    assign o_ex.dbg_tag     = i_dbg_tag;
    assign o_ex.dbg_pc      = i_pc;
    assign o_ex.dbg_inst    = i_inst;

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
`default_nettype none

module memory_stage #(
    parameter int MEM_ADDR_BITS = 8  // log2 of RAM depth in words
) (
    input  wire                              i_Clock,
    stage_if.consumer                        i_mem,
    output logic [rv_backend_pkg::XLEN-1:0]  o_load_data
);

    localparam int DEPTH = 1 << MEM_ADDR_BITS;

    logic [rv_backend_pkg::XLEN-1:0] ram [DEPTH];
    logic [MEM_ADDR_BITS-1:0]        word_addr;
    logic                            wr_en;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            ram[i] = '0;
        end
    end

    assign word_addr = i_mem.result[MEM_ADDR_BITS+1:2];  // Byte address to word index
    assign wr_en     = i_mem.mem_wr_enable && (i_mem.inst_op == rv_backend_pkg::OPC_STORE);

    always_ff @(posedge i_Clock) begin
        if (wr_en)
            ram[word_addr] <= i_mem.data_b;
    end

    // Read port, only loads see the RAM word
    always_ff @(posedge i_Clock) begin
        if (i_mem.is_load)
            o_load_data <= ram[word_addr];
        else
            o_load_data <= '0;
    end

endmodule

`default_nettype wire

//--- logic/pipeline_ex_mem.sv
`default_nettype none

module pipeline_ex_mem (
    input  wire       i_Clock,
    input  wire       i_reset,
    input  wire       i_flush,   // Drops the writes of the captured instruction
    stage_if.consumer i_ex,
    stage_if.producer o_mem
);

    always_ff @(posedge i_Clock) begin
        if (i_reset) begin
            o_mem.pc              <= '0;
            o_mem.inst_op         <= '0;
            o_mem.result          <= '0;
            o_mem.data_b          <= '0;
            o_mem.mem_wr_enable   <= 1'b0;
            o_mem.reg_wr_addr     <= '0;
            o_mem.reg_wr_enable   <= 1'b0;
            o_mem.reg_wr_data_sel <= '0;
            o_mem.is_load         <= 1'b0;
            o_mem.dbg_tag         <= '0;
            o_mem.dbg_pc          <= '0;
            o_mem.dbg_inst        <= '0;
        end else begin
            o_mem.pc              <= i_ex.pc;
            o_mem.inst_op         <= i_ex.inst_op;
            o_mem.result          <= i_ex.result;
            o_mem.data_b          <= i_ex.data_b;
            o_mem.mem_wr_enable   <= i_flush ? 1'b0 : i_ex.mem_wr_enable;
            o_mem.reg_wr_addr     <= i_ex.reg_wr_addr;
            o_mem.reg_wr_enable   <= i_flush ? 1'b0 : i_ex.reg_wr_enable;
            o_mem.reg_wr_data_sel <= i_ex.reg_wr_data_sel;
            o_mem.is_load         <= i_ex.is_load;

            // Debug fields pass through a flush
            o_mem.dbg_tag         <= i_ex.dbg_tag;
            o_mem.dbg_pc          <= i_ex.dbg_pc;
            o_mem.dbg_inst        <= i_ex.dbg_inst;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_backend_pkg.sv
`default_nettype none

package rv_backend_pkg;

    localparam int XLEN          = 32;  // Data and PC width
    localparam int REG_ADDR_BITS = 5;
    localparam int DBG_TAG_BITS  = 8;

    localparam logic [6:0] OPC_OP     = 7'b0110011;  // R-type ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // I-type ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;  // LW and SW width

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // SUB instead of ADD

    localparam logic [1:0] WB_SEL_ALU  = 2'd0;
    localparam logic [1:0] WB_SEL_MEM  = 2'd1;
    localparam logic [1:0] WB_SEL_LINK = 2'd2;

    // One instruction word seen in the R, I or S layout
    typedef union packed {
        struct packed {
            logic [6:0]               funct7;
            logic [REG_ADDR_BITS-1:0] rs2;
            logic [REG_ADDR_BITS-1:0] rs1;
            logic [2:0]               funct3;
            logic [REG_ADDR_BITS-1:0] rd;
            logic [6:0]               opcode;
        } r_fmt;
        struct packed {
            logic [11:0]              imm;
            logic [REG_ADDR_BITS-1:0] rs1;
            logic [2:0]               funct3;
            logic [REG_ADDR_BITS-1:0] rd;
            logic [6:0]               opcode;
        } i_fmt;
        struct packed {
            logic [6:0]               imm_hi;  // Immediate bits 11..5
            logic [REG_ADDR_BITS-1:0] rs2;
            logic [REG_ADDR_BITS-1:0] rs1;
            logic [2:0]               funct3;
            logic [4:0]               imm_lo;  // Immediate bits 4..0
            logic [6:0]               opcode;
        } s_fmt;
    } inst_u;

endpackage

`default_nettype wire

//--- logic/rv_backend_top.sv
`default_nettype none

module rv_backend_top #(
    parameter int MEM_ADDR_BITS = 8
) (
    input  wire                                      i_Clock,
    input  wire                                      i_reset,
    input  wire                                      i_flush,
    input  wire  [rv_backend_pkg::XLEN-1:0]          i_pc,
    input  wire  [31:0]                              i_inst,
    input  wire  [rv_backend_pkg::XLEN-1:0]          i_rs1_data,
    input  wire  [rv_backend_pkg::XLEN-1:0]          i_rs2_data,
    input  wire  [rv_backend_pkg::DBG_TAG_BITS-1:0]  i_dbg_tag,
    output logic                                     o_reg_wr_enable,
    output logic [rv_backend_pkg::REG_ADDR_BITS-1:0] o_reg_wr_addr,
    output logic [rv_backend_pkg::XLEN-1:0]          o_reg_wr_data,
    output logic [rv_backend_pkg::DBG_TAG_BITS-1:0]  o_dbg_tag,
    output logic [rv_backend_pkg::XLEN-1:0]          o_dbg_pc,
    output logic [31:0]                              o_dbg_inst
);

    stage_if ex_bus ();   // Execute to EX/MEM
    stage_if mem_bus ();  // EX/MEM to memory and writeback

    logic [rv_backend_pkg::XLEN-1:0] load_data;

    execute_stage u_execute (
        .i_pc       (i_pc),
        .i_inst     (i_inst),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .i_dbg_tag  (i_dbg_tag),
        .o_ex       (ex_bus.producer)
    );

    pipeline_ex_mem u_ex_mem (
        .i_Clock (i_Clock),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_ex    (ex_bus.consumer),
        .o_mem   (mem_bus.producer)
    );

    memory_stage #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_memory (
        .i_Clock     (i_Clock),
        .i_mem       (mem_bus.consumer),
        .o_load_data (load_data)
    );

    writeback_stage u_writeback (
        .i_Clock         (i_Clock),
        .i_reset         (i_reset),
        .i_mem           (mem_bus.consumer),
        .i_load_data     (load_data),
        .o_reg_wr_enable (o_reg_wr_enable),
        .o_reg_wr_addr   (o_reg_wr_addr),
        .o_reg_wr_data   (o_reg_wr_data),
        .o_dbg_tag       (o_dbg_tag),
        .o_dbg_pc        (o_dbg_pc),
        .o_dbg_inst      (o_dbg_inst)
    );

endmodule

`default_nettype wire

//--- logic/stage_if.sv
`default_nettype none

interface stage_if;

    logic [rv_backend_pkg::XLEN-1:0]          pc;
    logic [6:0]                               inst_op;
    logic [rv_backend_pkg::XLEN-1:0]          result;           // ALU result or address
    logic [rv_backend_pkg::XLEN-1:0]          data_b;           // Store data
    logic                                     mem_wr_enable;
    logic [rv_backend_pkg::REG_ADDR_BITS-1:0] reg_wr_addr;
    logic                                     reg_wr_enable;
    logic [1:0]                               reg_wr_data_sel;
    logic                                     is_load;
    logic [rv_backend_pkg::DBG_TAG_BITS-1:0]  dbg_tag;
    logic [rv_backend_pkg::XLEN-1:0]          dbg_pc;
    logic [31:0]                              dbg_inst;

    modport producer (
        output pc, inst_op, result, data_b, mem_wr_enable,
               reg_wr_addr, reg_wr_enable, reg_wr_data_sel, is_load,
               dbg_tag, dbg_pc, dbg_inst
    );

    modport consumer (
        input  pc, inst_op, result, data_b, mem_wr_enable,
               reg_wr_addr, reg_wr_enable, reg_wr_data_sel, is_load,
               dbg_tag, dbg_pc, dbg_inst
    );

endinterface

`default_nettype wire

//--- logic/writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  wire                                         i_Clock,
    input  wire                                         i_reset,
    stage_if.consumer                                   i_mem,
    input  wire  [rv_backend_pkg::XLEN-1:0]             i_load_data,
    output logic                                        o_reg_wr_enable,
    output logic [rv_backend_pkg::REG_ADDR_BITS-1:0]    o_reg_wr_addr,
    output logic [rv_backend_pkg::XLEN-1:0]             o_reg_wr_data,
    output logic [rv_backend_pkg::DBG_TAG_BITS-1:0]     o_dbg_tag,
    output logic [rv_backend_pkg::XLEN-1:0]             o_dbg_pc,
    output logic [31:0]                                 o_dbg_inst
);

    logic [rv_backend_pkg::XLEN-1:0] result_q;
    logic [rv_backend_pkg::XLEN-1:0] link_q;   // PC+4 for JALR
    logic [1:0]                      sel_q;

    always_ff @(posedge i_Clock) begin
        if (i_reset) begin
            result_q        <= '0;
            link_q          <= '0;
            sel_q           <= rv_backend_pkg::WB_SEL_ALU;
            o_reg_wr_enable <= 1'b0;
            o_reg_wr_addr   <= '0;
            o_dbg_tag       <= '0;
            o_dbg_pc        <= '0;
            o_dbg_inst      <= '0;
        end else begin
            result_q        <= i_mem.result;
            link_q          <= i_mem.pc + rv_backend_pkg::XLEN'(4);
            sel_q           <= i_mem.reg_wr_data_sel;
            o_reg_wr_enable <= i_mem.reg_wr_enable;
            o_reg_wr_addr   <= i_mem.reg_wr_addr;
            o_dbg_tag       <= i_mem.dbg_tag;
            o_dbg_pc        <= i_mem.dbg_pc;
            o_dbg_inst      <= i_mem.dbg_inst;
        end
    end

    always_comb begin
        case (sel_q)
            rv_backend_pkg::WB_SEL_MEM:  o_reg_wr_data = i_load_data;  // Already registered in RAM
            rv_backend_pkg::WB_SEL_LINK: o_reg_wr_data = link_q;
            default:                     o_reg_wr_data = result_q;
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the RV32I back-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_backend \
    --Mdir obj_dir \
    -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_backend
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with exit status $status"
    exit 1
fi

exit 0

//--- sim.f
logic/rv_backend_pkg.sv
logic/stage_if.sv
logic/execute_stage.sv
logic/pipeline_ex_mem.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/rv_backend_top.sv
verification/rv_backend_props.sv
verification/tb_rv_backend.sv

//--- verification/rv_backend_props.sv
`default_nettype none

module rv_backend_props (
    input wire                                     i_Clock,
    input wire                                     i_reset,
    input wire                                     i_flush,
    input wire [rv_backend_pkg::XLEN-1:0]          i_pc,
    input wire [31:0]                              i_inst,
    input wire [rv_backend_pkg::DBG_TAG_BITS-1:0]  i_dbg_tag,
    input wire                                     i_wr_enable,   // Top-level write enable
    input wire [rv_backend_pkg::DBG_TAG_BITS-1:0]  i_out_tag,
    input wire [rv_backend_pkg::XLEN-1:0]          i_out_pc,
    input wire [31:0]                              i_out_inst
);

    logic seen_reset = 1'b0;  // History before the first reset is meaningless

    always_ff @(posedge i_Clock) begin
        if (i_reset)
            seen_reset <= 1'b1;
    end

    a_reset_quiet: assert property (@(posedge i_Clock)
        seen_reset && ($past(i_reset) || $past(i_reset, 2)) |-> !i_wr_enable)
        else $error("Register write enabled during or right after reset");

    a_flush_quiet: assert property (@(posedge i_Clock)
        seen_reset && $past(i_flush, 2) |-> !i_wr_enable)
        else $error("Flushed instruction raised the register write enable");

    a_debug_pass: assert property (@(posedge i_Clock)
        seen_reset && !$past(i_reset) && !$past(i_reset, 2)
        |-> (i_out_tag == $past(i_dbg_tag, 2)) && (i_out_pc == $past(i_pc, 2))
            && (i_out_inst == $past(i_inst, 2)))
        else $error("Debug outputs differ from the values issued two edges earlier");

endmodule

bind rv_backend_top rv_backend_props u_props (
    .i_Clock     (i_Clock),
    .i_reset     (i_reset),
    .i_flush     (i_flush),
    .i_pc        (i_pc),
    .i_inst      (i_inst),
    .i_dbg_tag   (i_dbg_tag),
    .i_wr_enable (o_reg_wr_enable),
    .i_out_tag   (o_dbg_tag),
    .i_out_pc    (o_dbg_pc),
    .i_out_inst  (o_dbg_inst)
);

`default_nettype wire

//--- verification/tb_rv_backend.sv
`default_nettype none

module tb_rv_backend;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = 1000;

    logic        i_Clock;
    logic        i_reset;
    logic        i_flush;
    logic [31:0] i_pc;
    logic [31:0] i_inst;
    logic [31:0] i_rs1_data;
    logic [31:0] i_rs2_data;
    logic [7:0]  i_dbg_tag;
    wire         o_reg_wr_enable;
    wire  [4:0]  o_reg_wr_addr;
    wire  [31:0] o_reg_wr_data;
    wire  [7:0]  o_dbg_tag;
    wire  [31:0] o_dbg_pc;
    wire  [31:0] o_dbg_inst;

    logic [31:0] lfsr;
    logic [31:0] mirror [16];   // First 16 RAM words as seen by committed stores
    logic [45:0] exp_q [$];     // {enable, rd, data, tag} per issued slot

    rv_backend_top #(
        .MEM_ADDR_BITS (8)
    ) UUT (
        .i_Clock         (i_Clock),
        .i_reset         (i_reset),
        .i_flush         (i_flush),
        .i_pc            (i_pc),
        .i_inst          (i_inst),
        .i_rs1_data      (i_rs1_data),
        .i_rs2_data      (i_rs2_data),
        .i_dbg_tag       (i_dbg_tag),
        .o_reg_wr_enable (o_reg_wr_enable),
        .o_reg_wr_addr   (o_reg_wr_addr),
        .o_reg_wr_data   (o_reg_wr_data),
        .o_dbg_tag       (o_dbg_tag),
        .o_dbg_pc        (o_dbg_pc),
        .o_dbg_inst      (o_dbg_inst)
    );

    always #10 i_Clock = ~i_Clock;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // RV32I semantics of the supported ALU operations
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic drive_inputs(input logic flush, input logic [31:0] pc, input logic [31:0] inst,
                                input logic [31:0] a, input logic [31:0] b, input logic [7:0] tag);
        i_flush    = flush;
        i_pc       = pc;
        i_inst     = inst;
        i_rs1_data = a;
        i_rs2_data = b;
        i_dbg_tag  = tag;
    endtask

    task automatic issue_random;
        logic [31:0] r;
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic        sub;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  w;
        logic        flush;
        logic [11:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [7:0]  tag;
        logic [31:0] inst;
        logic [31:0] result;
        logic        wen;
        r      = random_bits(30);
        kind   = r[3:0];
        f3     = (r[6:4] == 3'b011) ? 3'b000 : r[6:4];  // No SLTU
        sub    = r[7] && (f3 == 3'b000);
        rd     = r[12:8];
        rs1    = r[17:13];
        rs2    = r[22:18];
        w      = r[26:23];           // One of 16 words so loads hit stores
        flush  = (r[29:27] == 3'b000);
        imm    = 12'(random_bits(12));
        a      = random_bits(32);
        b      = random_bits(32);
        pc     = {30'(random_bits(30)), 2'b00};
        tag    = 8'(random_bits(8));
        inst   = {imm, rs1, f3, rd, 7'b0001011};  // Unknown opcode unless replaced
        result = '0;
        wen    = 1'b0;
        if (kind <= 4'd5) begin
            inst   = {sub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, rv_backend_pkg::OPC_OP};
            result = alu_model(f3, sub, a, b);
            wen    = 1'b1;
        end else if (kind <= 4'd9) begin
            if (f3 == 3'b001 || f3 == 3'b101)
                imm[11:5] = 7'b0;    // Shift amount only
            inst   = {imm, rs1, f3, rd, rv_backend_pkg::OPC_OP_IMM};
            result = alu_model(f3, 1'b0, a, {{20{imm[11]}}, imm});
            wen    = 1'b1;
        end else if (kind <= 4'd11) begin
            a      = {26'b0, w, 2'b00} - {{20{imm[11]}}, imm};  // rs1 + imm lands on word w
            inst   = {imm, rs1, 3'b010, rd, rv_backend_pkg::OPC_LOAD};
            result = mirror[w];
            wen    = 1'b1;
        end else if (kind <= 4'd13) begin
            a    = {26'b0, w, 2'b00} - {{20{imm[11]}}, imm};
            inst = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_backend_pkg::OPC_STORE};
            if (!flush)
                mirror[w] = b;       // Flushed stores never reach the RAM
        end else if (kind == 4'd14) begin
            inst   = {imm, rs1, 3'b000, rd, rv_backend_pkg::OPC_JALR};
            result = pc + 32'd4;     // Link value
            wen    = 1'b1;
        end
        drive_inputs(flush, pc, inst, a, b, tag);
        exp_q.push_back({wen && !flush && (rd != 5'd0), rd, result, tag});
    endtask

    task automatic check_oldest;
        logic [45:0] e;
        e = exp_q.pop_front();
        expect_equal("o_reg_wr_enable", {31'b0, e[45]}, {31'b0, o_reg_wr_enable});
        if (e[45]) begin
            expect_equal("o_reg_wr_addr", {27'b0, e[44:40]}, {27'b0, o_reg_wr_addr});
            expect_equal("o_reg_wr_data", e[39:8], o_reg_wr_data);
        end
        expect_equal("o_dbg_tag", {24'b0, e[7:0]}, {24'b0, o_dbg_tag});
    endtask

    initial begin
        i_Clock = 1'b0;
        i_reset = 1'b1;
        lfsr    = 32'd80568;
        drive_inputs(1'b0, '0, '0, '0, '0, '0);
        for (int i = 0; i < 16; i++)
            mirror[i] = '0;
        repeat (5) @(posedge i_Clock);
        #2;
        i_reset = 1'b0;
        for (int n = 0; n < NUM_INSTR + 2; n++) begin
            if (n < NUM_INSTR) begin
                issue_random();
            end else begin
                drive_inputs(1'b0, '0, '0, '0, '0, '0);  // Drain with bubbles
                exp_q.push_back('0);
            end
            @(negedge i_Clock);
            if (exp_q.size() == 3)
                check_oldest();      // Slot issued two edges earlier
            @(posedge i_Clock);
            #2;
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_Clock);
            cycles++;
        end
        $display("Simulation did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
